//--- design/decoderPkg.sv
/*
 Shared definitions for the pipelined instruction decoder.
 Holds the reduced opcode and function encodings, the instruction
 field positions and the structs passed between the decode stages.
 Design files refer to everything here through decoderPkg:: names.
*/
`default_nettype none

package decoderPkg;

	parameter int ValueWidth = 64;

	typedef logic [31:0] instrWord;

	// ========================================
	// Encodings
	// ========================================
	typedef enum logic [6:0] {
		R2   = 7'h02,
		ADDI = 7'h04,
		ANDI = 7'h08,
		ORI  = 7'h09,
		XORI = 7'h0A,
		LDB  = 7'h10,
		LDBU = 7'h11,
		LDW  = 7'h12,
		LDWU = 7'h13,
		LDT  = 7'h14,
		LDTU = 7'h15,
		LDO  = 7'h16,
		STB  = 7'h18,
		STW  = 7'h19,
		STT  = 7'h1A,
		STO  = 7'h1B,
		JEQ  = 7'h20,
		JNE  = 7'h21,
		JLT  = 7'h22,
		JGE  = 7'h23,
		JMP  = 7'h28,
		RTS  = 7'h29,
		EXI  = 7'h30,
		NOP  = 7'h3F
	} opcodeE;

	typedef enum logic [4:0] {
		ADD = 5'd0,
		SUB = 5'd1,
		AND = 5'd2,
		OR  = 5'd3,
		XOR = 5'd4,
		MUL = 5'd8,
		DIV = 5'd9
	} funcE;

	typedef enum logic [1:0] {byt, wyde, tetra, octa} memSizeE;

	// ========================================
	// Field positions
	// ========================================
	localparam int OpHi = 6;
	localparam int OpLo = 0;
	localparam int FnHi = 31;
	localparam int FnLo = 27;
	localparam int RtHi = 11;
	localparam int RtLo = 7;
	localparam int RaHi = 16;
	localparam int RaLo = 12;
	localparam int RbHi = 21;
	localparam int RbLo = 17;
	localparam int RcHi = 26;
	localparam int RcLo = 22;
	localparam int ImmHi = 31;
	localparam int ImmLo = 17;
	// Branch offset is split, upper part above the Rt slot
	localparam int BrUpHi = 31;
	localparam int BrUpLo = 22;
	localparam int BrDnHi = 11;
	localparam int BrDnLo = 7;
	localparam int JmpHi = 31;
	localparam int JmpLo = 7;
	localparam int PfxHi = 31;
	localparam int PfxLo = 7;

	localparam int ImmWidth = ImmHi - ImmLo + 1;
	localparam int PrefixWidth = PfxHi - PfxLo + 1;
	// Prefixed immediate, payload stacked on the 15 instruction bits
	localparam int ExtWidth = PrefixWidth + ImmWidth;

	// ========================================
	// Structs
	// ========================================
	typedef struct packed {
		instrWord ir;
		logic pending;
		logic [PrefixWidth-1:0] prefix;
	} fetchWord;

	typedef struct packed {
		logic [4:0] Ra;
		logic [4:0] Rb;
		logic [4:0] Rc;
		logic [4:0] Rt;
		logic rfwr;
	} regSpec;

	typedef struct packed {
		logic load;
		logic loadZero;
		logic store;
		logic jxx;
		logic jmp;
		logic rts;
		logic multiCycle;
		logic illegal;
		logic hasImm;
		logic usesPrefix;
		memSizeE memSize;
	} classFlags;

	// Opcode groups used by more than one stage
	function automatic logic isLoad(opcodeE op);
		return op inside {LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO};
	endfunction

	function automatic logic isStore(opcodeE op);
		return op inside {STB, STW, STT, STO};
	endfunction

	function automatic logic isBranch(opcodeE op);
		return op inside {JEQ, JNE, JLT, JGE};
	endfunction

	function automatic logic carriesImm(opcodeE op);
		return (op inside {ADDI, ANDI, ORI, XORI}) || isLoad(op) || isStore(op);
	endfunction

endpackage

`default_nettype wire

//--- design/prefixCapture.sv
/*
 Input stage of the decoder.
 Registers each valid instruction word one cycle after its strobe.
 EXI words are held back as a pending prefix and leave no output;
 the next non-EXI word carries the held payload with it.
*/
`timescale 1ns/1ps
`default_nettype none

module prefixCapture (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 irValid,
	input  decoderPkg::instrWord ir,
	output decoderPkg::fetchWord fetch,
	output logic                 fetchValid
);

	logic isExi;
	logic prefixPending;
	logic [decoderPkg::PrefixWidth-1:0] prefixHeld;

	assign isExi = (ir[decoderPkg::OpHi:decoderPkg::OpLo] == decoderPkg::EXI);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			fetchValid <= 1'b0;
			prefixPending <= 1'b0;
		end
		else
		begin
			fetchValid <= irValid && !isExi;
			// A later EXI simply re-arms, a normal word consumes the prefix
			if (irValid)
				prefixPending <= isExi;
		end
	end

	always_ff @(posedge clk)
	begin
		if (irValid)
		begin
			if (isExi)
				prefixHeld <= ir[decoderPkg::PfxHi:decoderPkg::PfxLo];
			else
			begin
				fetch.ir <= ir;
				fetch.pending <= prefixPending;
				fetch.prefix <= prefixHeld;
			end
		end
	end

	// Prefix words never reach the decode stages
	exiNeverIssued: assert property (@(posedge clk) disable iff (!arstN)
		fetchValid |-> fetch.ir[decoderPkg::OpHi:decoderPkg::OpLo] != decoderPkg::EXI);

endmodule

`default_nettype wire

//--- design/fieldDecoder.sv
/*
 Combinational decode of register specifiers and class flags.
 Reads the registered fetch word and produces the register fields,
 the register-file write flag and the instruction class flags.
 An illegal opcode or R2 function suppresses every other flag.
*/
`timescale 1ns/1ps
`default_nettype none

module fieldDecoder (
	input  decoderPkg::fetchWord  fetch,
	output decoderPkg::regSpec    regs,
	output decoderPkg::classFlags flags
);

	decoderPkg::opcodeE op;
	decoderPkg::funcE fn;

	assign op = decoderPkg::opcodeE'(fetch.ir[decoderPkg::OpHi:decoderPkg::OpLo]);
	assign fn = decoderPkg::funcE'(fetch.ir[decoderPkg::FnHi:decoderPkg::FnLo]);

	// ========================================
	// Register specifiers
	// ========================================
	always_comb
	begin
		regs.Ra = fetch.ir[decoderPkg::RaHi:decoderPkg::RaLo];
		regs.Rb = fetch.ir[decoderPkg::RbHi:decoderPkg::RbLo];
		// Store data sits in the Rt slot
		if (decoderPkg::isStore(op))
			regs.Rc = fetch.ir[decoderPkg::RtHi:decoderPkg::RtLo];
		else
			regs.Rc = fetch.ir[decoderPkg::RcHi:decoderPkg::RcLo];

		if (decoderPkg::isStore(op) || decoderPkg::isBranch(op))
			regs.Rt = 5'd0;
		else if (op inside {decoderPkg::JMP, decoderPkg::RTS, decoderPkg::NOP})
			regs.Rt = 5'd0;
		else
			regs.Rt = fetch.ir[decoderPkg::RtHi:decoderPkg::RtLo];

		regs.rfwr = 1'b0;
		flags = '0;
		flags.memSize = decoderPkg::octa;

		case (op)
			decoderPkg::R2:
			begin
				regs.rfwr = 1'b1;
				case (fn)
					decoderPkg::MUL, decoderPkg::DIV:
						flags.multiCycle = 1'b1;
					decoderPkg::ADD, decoderPkg::SUB, decoderPkg::AND,
					decoderPkg::OR, decoderPkg::XOR:
						flags.multiCycle = 1'b0;
					default:
						flags.illegal = 1'b1;
				endcase
			end
			decoderPkg::ADDI, decoderPkg::ANDI, decoderPkg::ORI, decoderPkg::XORI:
				regs.rfwr = 1'b1;
			decoderPkg::LDB, decoderPkg::LDW, decoderPkg::LDT, decoderPkg::LDO:
			begin
				regs.rfwr = 1'b1;
				flags.load = 1'b1;
				flags.multiCycle = 1'b1;
			end
			decoderPkg::LDBU, decoderPkg::LDWU, decoderPkg::LDTU:
			begin
				regs.rfwr = 1'b1;
				flags.load = 1'b1;
				flags.loadZero = 1'b1;
				flags.multiCycle = 1'b1;
			end
			decoderPkg::STB, decoderPkg::STW, decoderPkg::STT, decoderPkg::STO:
			begin
				flags.store = 1'b1;
				flags.multiCycle = 1'b1;
			end
			decoderPkg::JEQ, decoderPkg::JNE, decoderPkg::JLT, decoderPkg::JGE:
				flags.jxx = 1'b1;
			decoderPkg::JMP:
				flags.jmp = 1'b1;
			decoderPkg::RTS:
				flags.rts = 1'b1;
			decoderPkg::EXI, decoderPkg::NOP:
				flags.illegal = 1'b0;
			default:
				flags.illegal = 1'b1;
		endcase

		// Access size from the size letter of the mnemonic
		case (op)
			decoderPkg::LDB, decoderPkg::LDBU, decoderPkg::STB:
				flags.memSize = decoderPkg::byt;
			decoderPkg::LDW, decoderPkg::LDWU, decoderPkg::STW:
				flags.memSize = decoderPkg::wyde;
			decoderPkg::LDT, decoderPkg::LDTU, decoderPkg::STT:
				flags.memSize = decoderPkg::tetra;
			default:
				flags.memSize = decoderPkg::octa;
		endcase

		flags.hasImm = decoderPkg::carriesImm(op);
		flags.usesPrefix = flags.hasImm && fetch.pending;

		// Illegal words must not start any unit
		if (flags.illegal)
		begin
			regs.rfwr = 1'b0;
			flags = '0;
			flags.illegal = 1'b1;
			flags.memSize = decoderPkg::octa;
		end
	end

endmodule

`default_nettype wire

//--- design/immBuilder.sv
/*
 Combinational immediate and branch offset generation.
 Pads the 15-bit immediate by opcode, replaces it with the 40-bit
 prefixed value when an EXI payload is pending, and forms the
 sign-extended, halfword-scaled target offset for jxx and JMP.
*/
`timescale 1ns/1ps
`default_nettype none

module immBuilder #(
	parameter int ValueWidth = 64
) (
	input  decoderPkg::fetchWord  fetch,
	output logic [ValueWidth-1:0] imm,
	output logic [ValueWidth-1:0] jmpTgt
);

	decoderPkg::opcodeE op;
	logic [decoderPkg::ImmWidth-1:0] imm15;
	logic [decoderPkg::ExtWidth-1:0] extImm;
	logic [14:0] brOff;
	logic [24:0] jmpOff;
	logic [ValueWidth-1:0] baseImm;

	assign op = decoderPkg::opcodeE'(fetch.ir[decoderPkg::OpHi:decoderPkg::OpLo]);
	assign imm15 = fetch.ir[decoderPkg::ImmHi:decoderPkg::ImmLo];
	assign extImm = {fetch.prefix, imm15};
	assign brOff = {fetch.ir[decoderPkg::BrUpHi:decoderPkg::BrUpLo],
		fetch.ir[decoderPkg::BrDnHi:decoderPkg::BrDnLo]};
	assign jmpOff = fetch.ir[decoderPkg::JmpHi:decoderPkg::JmpLo];

	// ========================================
	// Immediate
	// ========================================
	always_comb
	begin
		case (op)
			decoderPkg::ANDI:
				baseImm = {{(ValueWidth - decoderPkg::ImmWidth){1'b1}}, imm15};
			decoderPkg::ORI, decoderPkg::XORI:
				baseImm = ValueWidth'(imm15);
			default:
				// ADDI and memory displacements are signed
				if (decoderPkg::carriesImm(op))
					baseImm = ValueWidth'($signed(imm15));
				else
					baseImm = '0;
		endcase

		// Prefix on an opcode without an immediate is dropped
		if (fetch.pending && decoderPkg::carriesImm(op))
			imm = ValueWidth'($signed(extImm));
		else
			imm = baseImm;
	end

	// ========================================
	// Branch target offset
	// ========================================
	always_comb
	begin
		if (decoderPkg::isBranch(op))
			jmpTgt = ValueWidth'($signed({brOff, 1'b0}));
		else if (op == decoderPkg::JMP)
			jmpTgt = ValueWidth'($signed({jmpOff, 1'b0}));
		else
			jmpTgt = '0;
	end

endmodule

`default_nettype wire

//--- design/decodeLatch.sv
/*
 Output stage of the decoder.
 Derives the memory and flow-change summaries from the class flags
 and registers the full decode result on each fetch strobe.
 decoValid follows fetchValid by one cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module decodeLatch #(
	parameter int ValueWidth = 64
) (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  fetchValid,
	input  decoderPkg::regSpec    regsIn,
	input  decoderPkg::classFlags flagsIn,
	input  logic [ValueWidth-1:0] immIn,
	input  logic [ValueWidth-1:0] tgtIn,
	output logic                  decoValid,
	output logic                  flowChg,
	output logic                  mem,
	output decoderPkg::regSpec    regs,
	output decoderPkg::classFlags flags,
	output logic [ValueWidth-1:0] imm,
	output logic [ValueWidth-1:0] jmpTgt
);

	logic memNext;
	logic flowNext;

	assign memNext = flagsIn.load || flagsIn.store;
	assign flowNext = flagsIn.jxx || flagsIn.jmp || flagsIn.rts;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			decoValid <= 1'b0;
		else
			decoValid <= fetchValid;
	end

	// Result is only meaningful while decoValid is high
	always_ff @(posedge clk)
	begin
		if (fetchValid)
		begin
			regs <= regsIn;
			flags <= flagsIn;
			imm <= immIn;
			jmpTgt <= tgtIn;
			mem <= memNext;
			flowChg <= flowNext;
		end
	end

	loadStoreExclusive: assert property (@(posedge clk) disable iff (!arstN)
		decoValid |-> !(flags.load && flags.store));

endmodule

`default_nettype wire

//--- design/decodeUnit.sv
/*
 Top level of the pipelined instruction decoder.
 Accepts one instruction word per irValid strobe and presents the
 decoded result with decoValid two cycles later. There is no
 back-pressure, so each result must be taken when it appears.
*/
`timescale 1ns/1ps
`default_nettype none

module decodeUnit #(
	parameter int ValueWidth = decoderPkg::ValueWidth
) (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic                  irValid,
	input  decoderPkg::instrWord  ir,
	output logic                  decoValid,
	output decoderPkg::regSpec    regs,
	output decoderPkg::classFlags flags,
	output logic                  flowChg,
	output logic                  mem,
	output logic [ValueWidth-1:0] imm,
	output logic [ValueWidth-1:0] jmpTgt
);

	decoderPkg::fetchWord fetch;
	logic fetchValid;
	decoderPkg::regSpec decRegs;
	decoderPkg::classFlags decFlags;
	logic [ValueWidth-1:0] decImm;
	logic [ValueWidth-1:0] decTgt;

	prefixCapture u_capture (
		.clk        (clk),
		.arstN      (arstN),
		.irValid    (irValid),
		.ir         (ir),
		.fetch      (fetch),
		.fetchValid (fetchValid)
	);

	fieldDecoder u_fields (
		.fetch (fetch),
		.regs  (decRegs),
		.flags (decFlags)
	);

	immBuilder #(.ValueWidth(ValueWidth)) u_imm (
		.fetch  (fetch),
		.imm    (decImm),
		.jmpTgt (decTgt)
	);

	decodeLatch #(.ValueWidth(ValueWidth)) u_latch (
		.clk        (clk),
		.arstN      (arstN),
		.fetchValid (fetchValid),
		.regsIn     (decRegs),
		.flagsIn    (decFlags),
		.immIn      (decImm),
		.tgtIn      (decTgt),
		.decoValid  (decoValid),
		.flowChg    (flowChg),
		.mem        (mem),
		.regs       (regs),
		.flags      (flags),
		.imm        (imm),
		.jmpTgt     (jmpTgt)
	);

endmodule

`default_nettype wire

//--- verif/decodeChecks.svh
/*
 Check helpers for the decoder testbench, included inside the
 testbench module. Provides the value compare task, the Galois LFSR
 used for idle gaps and the unpacking of one pattern record into
 an expected result.
*/
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

// One expected decode result, with the cycle it must appear in
typedef struct packed {
	logic [31:0] ir;
	logic wantOut;
	logic [4:0] Ra;
	logic [4:0] Rb;
	logic [4:0] Rc;
	logic [4:0] Rt;
	logic rfwr;
	logic [11:0] flags;
	logic flowChg;
	logic mem;
	logic [63:0] imm;
	logic [63:0] tgt;
	int dueCycle;
} expRecord;

task automatic compareValue(input string name, input logic [63:0] actual,
	input logic [63:0] expected);
	if (actual !== expected)
	begin
		errorCount++;
		$display("mismatch at %0t ns: %s got %h expected %h", $time, name, actual, expected);
		$display("TEST FAIL");
		$fatal(1, "stopping at the first error");
	end
endtask

// Right-shifting Galois LFSR, taps for x^32 + x^31 + x^29 + x + 1
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
	return (state >> 1) ^ (state[0] ? 32'hD000_0001 : 32'h0);
endfunction

function automatic expRecord unpackRecord(input int k);
	expRecord r;
	int base;
	base = k * RecWords;
	r.ir = patMem[base][31:0];
	r.wantOut = patMem[base + 1][0];
	r.Ra = patMem[base + 2][4:0];
	r.Rb = patMem[base + 3][4:0];
	r.Rc = patMem[base + 4][4:0];
	r.Rt = patMem[base + 5][4:0];
	r.rfwr = patMem[base + 6][0];
	r.flags = patMem[base + 7][11:0];
	r.flowChg = patMem[base + 8][0];
	r.mem = patMem[base + 9][0];
	r.imm = patMem[base + 10];
	r.tgt = patMem[base + 11];
	r.dueCycle = 0;
	return r;
endfunction

`endif

//--- verif/decodeUnitTb.sv
/*
 Testbench for the pipelined instruction decoder.
 Reads instruction words and expected results from the pattern file,
 drives them with random idle gaps and checks every decoded result,
 including that it appears exactly two cycles after its strobe.
*/
`timescale 1ns/1ps
`default_nettype none

module decodeUnitTb;

	localparam int RecWords = 12;
	localparam int MaxRecords = 64;
	localparam int MemWords = RecWords * MaxRecords;

	logic clk;
	logic arstN;
	logic irValid;
	decoderPkg::instrWord ir;
	logic decoValid;
	decoderPkg::regSpec regs;
	decoderPkg::classFlags flags;
	logic flowChg;
	logic mem;
	logic [63:0] imm;
	logic [63:0] jmpTgt;

	logic [63:0] patMem [0:MemWords-1];
	int recordCount;
	int errorCount;
	int cycleCount;
	int cycleLimit;
	logic [31:0] lfsrState;

	`include "decodeChecks.svh"

	expRecord pending [$];

	decodeUnit #(.ValueWidth(64)) u_dut (
		.clk       (clk),
		.arstN     (arstN),
		.irValid   (irValid),
		.ir        (ir),
		.decoValid (decoValid),
		.regs      (regs),
		.flags     (flags),
		.flowChg   (flowChg),
		.mem       (mem),
		.imm       (imm),
		.jmpTgt    (jmpTgt)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ========================================
	// Cycle count and timeout
	// ========================================
	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			$display("timeout: decoder results did not arrive within %0d cycles", cycleLimit);
			$display("TEST FAIL");
			$fatal(1, "run aborted");
		end
	end

	// Results are sampled mid-cycle, away from the rising edge
	always @(negedge clk)
	begin
		expRecord e;
		if (arstN && decoValid)
		begin
			if (pending.size() == 0)
			begin
				$display("decoValid was raised with no result expected at %0t ns", $time);
				$display("TEST FAIL");
				$fatal(1, "unexpected output");
			end
			else
			begin
				e = pending.pop_front();
				compareValue("decoValid cycle", 64'(cycleCount), 64'(e.dueCycle));
				compareValue("regs.Ra", 64'(regs.Ra), 64'(e.Ra));
				compareValue("regs.Rb", 64'(regs.Rb), 64'(e.Rb));
				compareValue("regs.Rc", 64'(regs.Rc), 64'(e.Rc));
				compareValue("regs.Rt", 64'(regs.Rt), 64'(e.Rt));
				compareValue("regs.rfwr", 64'(regs.rfwr), 64'(e.rfwr));
				compareValue("flags", 64'(flags), 64'(e.flags));
				compareValue("flowChg", 64'(flowChg), 64'(e.flowChg));
				compareValue("mem", 64'(mem), 64'(e.mem));
				compareValue("imm", imm, e.imm);
				compareValue("jmpTgt", jmpTgt, e.tgt);
			end
		end
	end

	// ========================================
	// Stimulus
	// ========================================
	initial
	begin
		expRecord r;
		int gap;
		arstN = 1'b0;
		irValid = 1'b0;
		ir = '0;
		errorCount = 0;
		cycleCount = 0;
		cycleLimit = 1000;
		lfsrState = 32'h8f6f_152a;
		// Upper half set marks words that the file did not fill
		for (int i = 0; i < MemWords; i++)
			patMem[i] = {32'hFFFF_FFFF, 32'(i)};
		$readmemh("verif/decodePatterns.hex", patMem);
		recordCount = 0;
		while (recordCount < MaxRecords && patMem[recordCount * RecWords][63:32] == 32'h0)
			recordCount++;
		if (recordCount == 0)
		begin
			$display("the pattern file holds no records");
			$display("TEST FAIL");
			$fatal(1, "no stimulus");
		end
		cycleLimit = recordCount * 6 + 50;

		repeat (8) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;

		for (int k = 0; k < recordCount; k++)
		begin
			@(negedge clk);
			r = unpackRecord(k);
			irValid = 1'b1;
			ir = r.ir;
			r.dueCycle = cycleCount + 2;
			if (r.wantOut)
				pending.push_back(r);
			gap = 0;
			for (int b = 0; b < 2; b++)
			begin
				gap = (gap << 1) | int'(lfsrState[0]);
				lfsrState = lfsrStep(lfsrState);
			end
			repeat (gap)
			begin
				@(negedge clk);
				irValid = 1'b0;
			end
		end
		@(negedge clk);
		irValid = 1'b0;

		while (pending.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk);

		if (errorCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/decodePatterns.hex
// Columns: ir wantOut Ra Rb Rc Rt rfwr flags flowChg mem imm jmpTgt
// flags bits: load loadZero store jxx jmp rts multiCycle illegal hasImm usesPrefix memSize[1:0]
00C41202 1 01 02 03 04 1 003 0 0 0 0
094C7402 1 07 06 05 08 1 003 0 0 0 0
40421082 1 01 01 01 01 1 023 0 0 0 0
48864282 1 04 03 02 05 1 023 0 0 0 0
28001102 1 01 00 00 02 0 013 0 0 0 0
00003305 1 03 00 00 06 0 013 0 0 0 0
FFFE2184 1 02 1F 1F 03 1 00B 0 0 FFFFFFFFFFFFFFFF 0
24681084 1 01 14 11 01 1 00B 0 0 1234 0
01E05288 1 05 10 07 05 1 00B 0 0 FFFFFFFFFFFF80F0 0
80020489 1 00 01 00 09 1 00B 0 0 4001 0
FFFE320A 1 03 1F 1F 04 1 00B 0 0 7FFF 0
00201110 1 01 10 00 02 1 828 0 1 10 0
FFF02191 1 02 18 1F 03 1 C28 0 1 FFFFFFFFFFFFFFF8 0
00083212 1 03 04 00 04 1 829 0 1 4 0
00004293 1 04 00 00 05 1 C29 0 1 0 0
02005314 1 05 00 08 06 1 82A 0 1 100 0
00406395 1 06 00 01 07 1 C2A 0 1 20 0
80007416 1 07 00 00 08 1 82B 0 1 FFFFFFFFFFFFC000 0
00101518 1 01 08 0A 00 0 228 0 1 8 0
FFFC2599 1 02 1E 0B 00 0 229 0 1 FFFFFFFFFFFFFFFE 0
0004361A 1 03 02 0C 00 0 22A 0 1 2 0
0000469B 1 04 00 0D 00 0 22B 0 1 0 0
004412A0 1 01 02 01 00 0 103 1 0 0 4A
FFC83E21 1 03 04 1F 00 0 103 1 0 0 FFFFFFFFFFFFFFF8
000C5022 1 05 06 00 00 0 103 1 0 0 0
000000A3 1 00 00 00 00 0 103 1 0 0 2
00008028 1 08 00 00 00 0 083 1 0 0 200
FFFFFFA8 1 1F 1F 1F 00 0 083 1 0 0 FFFFFFFFFFFFFFFE
000011A9 1 01 00 00 00 0 043 1 0 0 0
0000003F 1 00 00 00 00 0 003 0 0 0 0
000000B0 0 00 00 00 00 0 000 0 0 0 0
000A1104 1 01 05 00 02 1 00F 0 0 8005 0
FFFFFFB0 0 00 00 00 00 0 000 0 0 0 0
00202196 1 02 10 00 03 1 82F 0 1 FFFFFFFFFFFF8010 0
00000130 0 00 00 00 00 0 000 0 0 0 0
00C41202 1 01 02 03 04 1 003 0 0 0 0
24681084 1 01 14 11 01 1 00B 0 0 1234 0
00055E30 0 00 00 00 00 0 000 0 0 0 0
000001B0 0 00 00 00 00 0 000 0 0 0 0
000E0089 1 00 07 00 01 1 00F 0 0 18007 0

//--- verilog.f
+incdir+verif
design/decoderPkg.sv
design/prefixCapture.sv
design/fieldDecoder.sv
design/immBuilder.sv
design/decodeLatch.sv
design/decodeUnit.sv
verif/decodeUnitTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module decodeUnitTb -Mdir obj_dir -o decodeSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/decodeSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
	exit 0
fi
exit 1
